// File: list.f
+incdir+include
design/wisc_pkg.sv
design/busPort.sv
design/instrQueue.sv
design/control.sv
design/execUnit.sv
design/wiscCore.sv
sim/wiscCore_properties.sv
sim/wiscCore_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the WISC engine testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module wiscCore_tb -o VwiscCore_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/VwiscCore_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -qx "all tests passed" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1

// File: sim/wiscCore_tb.sv
/*
	Testbench for the WISC instruction-stream engine
	Pushes instruction words over the host bus, mirrors them in a reference
	model and compares the status word and registers read back
*/
`include "wisc_settings.svh"

module wiscCore_tb
	import wisc_pkg::*;
();

	localparam int ackTimeout   = 20;       // Cycles a bus cycle waits for ack
	localparam int levelPolls   = 60;       // Status reads while the queue drains
	localparam int compareLimit = 5000;     // Cycles main waits on the compare process

	logic   clk;
	logic   rstN;
	wbReq_t wbIn;
	wbRsp_t wbOut;

	word_t      mRegs [`NUM_REGS];          // Model register file
	logic [7:0] mErr;                       // Model error count
	logic       mHalted;

	integer seed;
	int     errors;
	int     testsRun;
	int     testsFailed;
	int     errBase;                        // Error count when the current test began
	logic   compareReq;                     // Main asks for a compare pass
	logic [`QUEUE_LEVEL_W-1:0] expLevel;    // Level the compare waits for

	opcode_t imm1Ops [8] = '{5'b01000, 5'b01001, 5'b01010, 5'b01011,
		5'b10100, 5'b10101, 5'b10110, 5'b10111};
	opcode_t regOps [8] = '{5'b11011, 5'b11010, 5'b11100, 5'b11101,
		5'b11110, 5'b11111, 5'b11001, 5'b11011};    // ADD group twice
	opcode_t badOps [16] = '{5'b00010, 5'b00011, 5'b00100, 5'b00101, 5'b00110, 5'b00111,
		5'b01100, 5'b01101, 5'b01110, 5'b01111, 5'b10000, 5'b10001, 5'b10011,
		5'b00001, 5'b00001, 5'b00001};      // Last three are NOPs

	wiscCore i_dut (.clk, .rstN, .wbIn, .wbOut);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic word_t rotateLeft(input word_t v, input logic [3:0] n);
		return (v << n) | (v >> (5'd16 - n));
	endfunction

	function automatic word_t rotateRight(input word_t v, input logic [3:0] n);
		return (v >> n) | (v << (5'd16 - n));
	endfunction

	function automatic word_t bitReverse(input word_t v);
		word_t r;
		for (int i = 0; i < 16; i++) r[i] = v[15 - i];
		return r;
	endfunction

	// One instruction against the model state
	function automatic void refExec(input word_t ins);
		word_t       rs;
		word_t       rt;
		word_t       immS;          // 5-bit immediate, signed
		word_t       immZ;
		logic [16:0] sum;
		word_t       res;
		regIdx_t     rd;
		logic        wr;
		if (mHalted) return;        // Nothing pops after HALT
		rs   = mRegs[ins[10:8]];
		rt   = mRegs[ins[7:5]];
		immS = {{11{ins[4]}}, ins[4:0]};
		immZ = {11'b0, ins[4:0]};
		sum  = {1'b0, rs} + {1'b0, rt};
		res  = '0;
		wr   = 1'b1;
		rd   = ins[4:2];                                    // R format
		if (ins[15:14] == 2'b01 || ins[15:13] == 3'b101) rd = ins[7:5];
		if (ins[15:11] == 5'b11000 || ins[15:11] == 5'b10010) rd = ins[10:8];
		case (ins[15:11])
			5'b00000: begin
				mHalted = 1'b1;
				wr      = 1'b0;
			end
			5'b00001: wr = 1'b0;
			5'b01000: res = rs + immS;
			5'b01001: res = immS - rs;
			5'b01010: res = rs ^ immZ;
			5'b01011: res = rs & ~immZ;
			5'b10100: res = rotateLeft(rs, ins[3:0]);
			5'b10101: res = rs << ins[3:0];
			5'b10110: res = rotateRight(rs, ins[3:0]);
			5'b10111: res = rs >> ins[3:0];
			5'b11011: case (ins[1:0])
				2'b00:   res = rs + rt;
				2'b01:   res = rt - rs;
				2'b10:   res = rs ^ rt;
				default: res = rs & ~rt;
			endcase
			5'b11010: case (ins[1:0])
				2'b00:   res = rotateLeft(rs, rt[3:0]);
				2'b01:   res = rs << rt[3:0];
				2'b10:   res = rotateRight(rs, rt[3:0]);
				default: res = rs >> rt[3:0];
			endcase
			5'b11100: res = {15'b0, rs == rt};
			5'b11101: res = {15'b0, $signed(rs) < $signed(rt)};
			5'b11110: res = {15'b0, $signed(rs) <= $signed(rt)};
			5'b11111: res = {15'b0, sum[16]};               // Unsigned carry out
			5'b11001: res = bitReverse(rs);
			5'b11000: res = {{8{ins[7]}}, ins[7:0]};
			5'b10010: res = {rs[7:0], ins[7:0]};
			default: begin
				mErr = mErr + 8'd1;                         // Discarded, counted only
				wr   = 1'b0;
			end
		endcase
		if (wr) mRegs[rd] = res;
	endfunction

	task automatic busWrite(input busAddr_t adr, input word_t dat, output logic ok);
		ok = 1'b0;
		@(posedge clk);
		wbIn <= '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		for (int n = 0; n < ackTimeout && !ok; n++) begin
			@(negedge clk);
			ok = wbOut.ack;
		end
		@(posedge clk);
		wbIn <= '0;                 // Idle after ack, abandons the cycle otherwise
		if (!ok) $display("Bus write of %h got no ack in %0d cycles, strobe dropped",
			dat, ackTimeout);
	endtask

	task automatic busRead(input busAddr_t adr, output word_t dat);
		logic ok;
		ok  = 1'b0;
		dat = '0;
		@(posedge clk);
		wbIn <= '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 16'h0000};
		for (int n = 0; n < ackTimeout && !ok; n++) begin
			@(negedge clk);
			ok = wbOut.ack;
		end
		if (ok) dat = wbOut.dat;    // Held through the ack cycle
		@(posedge clk);
		wbIn <= '0;
		if (!ok) begin
			$display("Bus read of address %0d got no ack in %0d cycles", adr, ackTimeout);
			errors++;
		end
	endtask

	task automatic check(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("Fail at time %0t: %s read %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic pushInstr(input word_t ins);
		logic ok;
		busWrite(`ADDR_STATUS, ins, ok);
		if (ok) refExec(ins);
		else errors++;
	endtask

	// Waits for the queue level, then status and every register
	task automatic compareState();
		word_t st;
		word_t rv;
		int    polls;
		busRead(`ADDR_STATUS, st);
		for (polls = 1; polls < levelPolls && st[11:8] != expLevel; polls++)
			busRead(`ADDR_STATUS, st);
		if (st[11:8] != expLevel) begin
			$display("Queue level stuck at %0d instead of %0d", st[11:8], expLevel);
			errors++;
		end
		check(st, {mHalted, 3'b000, expLevel, mErr}, "status word");
		for (int i = 0; i < `NUM_REGS; i++) begin
			busRead(busAddr_t'(`ADDR_REG_BASE + i), rv);
			check(rv, mRegs[i], $sformatf("register R%0d", i));
		end
	endtask

	initial begin : compareProc
		forever begin
			@(negedge clk);
			if (compareReq) begin
				compareState();
				compareReq = 1'b0;
			end
		end
	end

	task automatic requestCompare(input int lvl);
		expLevel   = lvl[`QUEUE_LEVEL_W-1:0];
		compareReq = 1'b1;
		for (int n = 0; n < compareLimit && compareReq; n++) @(negedge clk);
		if (compareReq) begin
			$display("Compare of status and registers did not finish in %0d cycles",
				compareLimit);
			errors++;
		end
	endtask

	task automatic finishTest(input string name);
		testsRun++;
		if (errors != errBase) testsFailed++;
		$display("Test %0d %s: %s", testsRun, name, (errors == errBase) ? "ok" : "mismatch");
		errBase = errors;
	endtask

	initial begin : mainProc
		logic [31:0] r;
		logic        ok;
		seed        = 55;
		errors      = 0;
		testsRun    = 0;
		testsFailed = 0;
		errBase     = 0;
		compareReq  = 1'b0;
		expLevel    = '0;
		mErr        = '0;
		mHalted     = 1'b0;
		for (int i = 0; i < `NUM_REGS; i++) mRegs[i] = '0;
		rstN <= 1'b0;
		wbIn <= '0;
		repeat (5) @(posedge clk);
		rstN <= 1'b1;

		requestCompare(0);
		finishTest("reset state");

		for (int i = 0; i < `NUM_REGS; i++) begin
			r = $random(seed);
			pushInstr({5'b11000, regIdx_t'(i), r[7:0]});     // LBI
			pushInstr({5'b10010, regIdx_t'(i), r[15:8]});    // SLBI
		end
		repeat (24) begin
			r = $random(seed);
			pushInstr({imm1Ops[r[13:11]], r[10:0]});
		end
		requestCompare(0);
		finishTest("immediate format");

		repeat (32) begin
			r = $random(seed);
			pushInstr({regOps[r[13:11]], r[10:0]});          // Random funct and Rd
		end
		requestCompare(0);
		finishTest("register format");

		repeat (20) begin
			r = $random(seed);
			pushInstr({badOps[r[14:11]], r[10:0]});
		end
		requestCompare(0);
		finishTest("unsupported opcodes");

		pushInstr(16'h0000);                                 // HALT
		repeat (`QUEUE_DEPTH) begin
			r = $random(seed);
			pushInstr({imm1Ops[r[13:11]], r[10:0]});         // Stays queued
		end
		r = $random(seed);
		busWrite(`ADDR_STATUS, {imm1Ops[r[13:11]], r[10:0]}, ok);
		if (ok) begin
			$display("Write to the full queue after HALT was acked");
			errors++;
		end
		requestCompare(`QUEUE_DEPTH);
		finishTest("halt and back-pressure");

		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			testsRun, testsRun - testsFailed, testsFailed, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

// File: sim/wiscCore_properties.sv
/*
	Bound checks for the WISC engine
	Bus handshake and push rules on busPort, halt and pop rules on execUnit
*/
module wiscCore_properties (
	input logic clk,
	input logic rstN,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic push,
	input logic full,
	input logic halted,
	input logic pop
);

	// Ack answers a strobe seen on the previous edge
	ackAfterStb: assert property (@(posedge clk) disable iff (!rstN)
		ack |-> $past(cyc && stb)) else $error("Ack without a preceding cyc and stb");

	noPushFull: assert property (@(posedge clk) disable iff (!rstN)
		push |-> !full) else $error("Push while the queue is full");

	// Sticky until reset
	haltHolds: assert property (@(posedge clk) disable iff (!rstN)
		halted |=> halted) else $error("Halted fell without reset");

	noPopHalted: assert property (@(posedge clk) disable iff (!rstN)
		halted |-> !pop) else $error("Pop while halted");

endmodule

bind busPort wiscCore_properties busProps (.clk, .rstN, .cyc(wbIn.cyc), .stb(wbIn.stb),
	.ack(wbOut.ack), .push, .full, .halted, .pop(1'b0));

bind execUnit wiscCore_properties execProps (.clk, .rstN, .cyc(1'b0), .stb(1'b0),
	.ack(1'b0), .push(1'b0), .full(1'b0), .halted, .pop);

// File: design/wiscCore.sv
/*
	WISC instruction-stream engine top
	Host bus port feeds the instruction queue, which the execute unit drains
*/
`include "wisc_settings.svh"

module wiscCore
	import wisc_pkg::*;
(
	input  logic   clk,
	input  logic   rstN,
	input  wbReq_t wbIn,
	output wbRsp_t wbOut
);

	logic                      push;
	word_t                     pushData;
	logic                      full;
	logic [`QUEUE_LEVEL_W-1:0] level;
	logic                      valid;
	word_t                     head;
	logic                      pop;
	logic                      halted;
	logic [7:0]                errCount;
	regIdx_t                   rdIdx;
	word_t                     rdData;

	busPort i_busPort (
		.clk, .rstN, .wbIn, .wbOut,
		.push, .pushData, .full, .level,
		.halted, .errCount, .rdIdx, .rdData
	);

	instrQueue i_instrQueue (
		.clk, .rstN, .push, .pushData,
		.pop, .valid, .head, .full, .level
	);

	execUnit i_execUnit (
		.clk, .rstN, .valid, .head, .pop,
		.halted, .errCount, .rdIdx, .rdData
	);

endmodule

// File: design/execUnit.sv
/*
	Execute unit
	Pops one instruction per cycle from the queue and applies it to the
	register file. Holds the halt flag and the count of rejected opcodes,
	and gives the host a combinational register read port
*/
`include "wisc_settings.svh"

module execUnit
	import wisc_pkg::*;
(
	input  logic       clk,
	input  logic       rstN,
	input  logic       valid,       // Queue has an instruction
	input  word_t      head,        // Instruction at the queue head
	output logic       pop,
	output logic       halted,
	output logic [7:0] errCount,    // Wraps
	input  regIdx_t    rdIdx,
	output word_t      rdData
);

	ctrl_t       ctrl;
	word_t       regs [`NUM_REGS];
	regIdx_t     rsIdx;
	regIdx_t     rtIdx;
	regIdx_t     dstIdx;
	word_t       rsVal;
	word_t       rtVal;
	word_t       imm5Ext;
	word_t       imm8Ext;
	word_t       srcA;
	word_t       srcB;
	logic [16:0] sum;           // Bit 16 is carry out
	logic [3:0]  shAmt;
	logic [31:0] rolWide;
	logic [31:0] rorWide;
	logic        cmpBit;
	word_t       aluRes;
	word_t       specialRes;
	word_t       result;

	control i_control (
		.opCode (head[15:11]),
		.funct  (head[1:0]),
		.ctrl   (ctrl)
	);

	assign rsIdx = head[10:8];
	assign rtIdx = head[7:5];
	assign rsVal = regs[rsIdx];
	assign rtVal = regs[rtIdx];

	always_comb begin
		case (ctrl.dstSel)
			dstI1:   dstIdx = head[7:5];
			dstR:    dstIdx = head[4:2];
			default: dstIdx = head[10:8];   // Rs for LBI and SLBI
		endcase
	end

	assign imm5Ext = ctrl.signImm ? {{11{head[4]}}, head[4:0]} : {11'b0, head[4:0]};
	assign imm8Ext = ctrl.signImm ? {{8{head[7]}}, head[7:0]} : {8'b0, head[7:0]};

	// Subtraction is second operand plus inverted Rs plus one
	assign srcA    = ctrl.invSrc1 ? ~rsVal : rsVal;
	assign srcB    = ctrl.useImm ? imm5Ext : rtVal;
	assign sum     = {1'b0, srcA} + {1'b0, srcB} + {16'b0, ctrl.invSrc1};
	assign shAmt   = srcB[3:0];
	assign rolWide = {rsVal, rsVal} << shAmt;   // Upper half is the rotate left
	assign rorWide = {rsVal, rsVal} >> shAmt;   // Lower half is the rotate right

	always_comb begin
		case (ctrl.aluOp)
			aluRol:  aluRes = rolWide[31:16];
			aluSll:  aluRes = rsVal << shAmt;
			aluRor:  aluRes = rorWide[15:0];
			aluSrl:  aluRes = rsVal >> shAmt;
			aluAdd:  aluRes = sum[15:0];
			aluAndn: aluRes = rsVal & ~srcB;
			aluXor:  aluRes = rsVal ^ srcB;
			default: aluRes = '0;
		endcase
	end

	always_comb begin
		case (ctrl.cmpOp)
			cmpEq:   cmpBit = (rsVal == srcB);
			cmpLt:   cmpBit = ($signed(rsVal) < $signed(srcB));
			cmpLe:   cmpBit = ($signed(rsVal) <= $signed(srcB));
			default: cmpBit = sum[16];              // Unsigned Rs plus Rt carry
		endcase
	end

	always_comb begin
		specialRes = '0;
		case (ctrl.special)
			spBtr:   for (int i = 0; i < 16; i++) specialRes[i] = rsVal[15 - i];
			spLbi:   specialRes = imm8Ext;
			spSlbi:  specialRes = (rsVal << 8) | imm8Ext;
			default: specialRes = '0;
		endcase
	end

	always_comb begin
		if (ctrl.special != spNone) begin
			result = specialRes;
		end else if (ctrl.cmpSet) begin
			result = {15'b0, cmpBit};
		end else begin
			result = aluRes;
		end
	end

	assign pop    = valid & ~halted;    // Stalls the queue once halted
	assign rdData = regs[rdIdx];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			halted   <= 1'b0;
			errCount <= '0;
			for (int i = 0; i < `NUM_REGS; i++) regs[i] <= '0;
		end else if (pop) begin
			if (ctrl.err) begin
				errCount <= errCount + 8'd1;    // Discarded, state untouched
			end else if (ctrl.halt) begin
				halted <= 1'b1;                 // Sticky until reset
			end else if (ctrl.regWrite) begin
				regs[dstIdx] <= result;
			end
		end
	end

endmodule

// File: design/control.sv
/*
	Instruction decoder
	Maps opcode and funct to the control bundle for the execute unit.
	Branches, jumps, memory ops, siic and RTI are flagged through err
*/
module control
	import wisc_pkg::*;
(
	input  opcode_t opCode,
	input  funct_t  funct,      // R format function
	output ctrl_t   ctrl
);

	// Immediate format 1, Rd in bits 7..5, operand is the 5-bit immediate
	function automatic ctrl_t immFmt(input aluOp_t op, input logic sgn, input logic inv);
		ctrl_t c;
		c          = '0;
		c.dstSel   = dstI1;
		c.useImm   = 1'b1;
		c.signImm  = sgn;
		c.invSrc1  = inv;
		c.aluOp    = op;
		c.regWrite = 1'b1;
		return c;
	endfunction

	// R format, Rd in bits 4..2, operands Rs and Rt
	function automatic ctrl_t regFmt(input aluOp_t op, input logic inv);
		ctrl_t c;
		c          = '0;
		c.dstSel   = dstR;
		c.invSrc1  = inv;
		c.aluOp    = op;
		c.regWrite = 1'b1;
		return c;
	endfunction

	// Set-on-compare writes 0 or 1 to Rd
	function automatic ctrl_t cmpFmt(input cmpOp_t op);
		ctrl_t c;
		c        = regFmt(aluAdd, 1'b0);    // Adder feeds the carry compare
		c.cmpSet = 1'b1;
		c.cmpOp  = op;
		return c;
	endfunction

	always_comb begin
		ctrl        = '0;               // All inactive
		ctrl.dstSel = dstRs;
		case (opCode)
			5'b00000: ctrl.halt = 1'b1;                         // HALT
			5'b00001: ctrl.regWrite = 1'b0;                     // NOP

			5'b01000: ctrl = immFmt(aluAdd, 1'b1, 1'b0);        // ADDI
			5'b01001: ctrl = immFmt(aluAdd, 1'b1, 1'b1);        // SUBI as I minus Rs
			5'b01010: ctrl = immFmt(aluXor, 1'b0, 1'b0);        // XORI
			5'b01011: ctrl = immFmt(aluAndn, 1'b0, 1'b0);       // ANDNI
			5'b10100: ctrl = immFmt(aluRol, 1'b0, 1'b0);        // ROLI
			5'b10101: ctrl = immFmt(aluSll, 1'b0, 1'b0);        // SLLI
			5'b10110: ctrl = immFmt(aluRor, 1'b0, 1'b0);        // RORI
			5'b10111: ctrl = immFmt(aluSrl, 1'b0, 1'b0);        // SRLI

			5'b11001: begin                                     // BTR
				ctrl.dstSel   = dstR;
				ctrl.special  = spBtr;
				ctrl.regWrite = 1'b1;
			end
			5'b11011: begin
				case (funct)
					2'b00: ctrl = regFmt(aluAdd, 1'b0);         // ADD
					2'b01: ctrl = regFmt(aluAdd, 1'b1);         // SUB as Rt minus Rs
					2'b10: ctrl = regFmt(aluXor, 1'b0);         // XOR
					2'b11: ctrl = regFmt(aluAndn, 1'b0);        // ANDN
				endcase
			end
			5'b11010: begin
				case (funct)
					2'b00: ctrl = regFmt(aluRol, 1'b0);         // ROL
					2'b01: ctrl = regFmt(aluSll, 1'b0);         // SLL
					2'b10: ctrl = regFmt(aluRor, 1'b0);         // ROR
					2'b11: ctrl = regFmt(aluSrl, 1'b0);         // SRL
				endcase
			end
			5'b11100: ctrl = cmpFmt(cmpEq);                     // SEQ
			5'b11101: ctrl = cmpFmt(cmpLt);                     // SLT signed
			5'b11110: ctrl = cmpFmt(cmpLe);                     // SLE signed
			5'b11111: ctrl = cmpFmt(cmpCarry);                  // SCO

			5'b11000: begin                                     // LBI
				ctrl.signImm  = 1'b1;
				ctrl.special  = spLbi;
				ctrl.regWrite = 1'b1;
			end
			5'b10010: begin                                     // SLBI, zero-extended
				ctrl.special  = spSlbi;
				ctrl.regWrite = 1'b1;
			end

			default: ctrl.err = 1'b1;   // Branch, jump, ST, LD, STU, siic and RTI
		endcase
	end

endmodule

// File: design/instrQueue.sv
/*
	Instruction queue
	Circular FIFO of instruction words with a level count.
	Push and pop may happen on the same edge
*/
`include "wisc_settings.svh"

module instrQueue
	import wisc_pkg::*;
(
	input  logic                     clk,
	input  logic                     rstN,
	input  logic                     push,
	input  word_t                    pushData,
	input  logic                     pop,
	output logic                     valid,      // Not empty
	output word_t                    head,       // Oldest entry
	output logic                     full,
	output logic [`QUEUE_LEVEL_W-1:0] level
);

	localparam int depth  = `QUEUE_DEPTH;
	localparam int ptrW   = $clog2(depth);
	localparam int levelW = `QUEUE_LEVEL_W;

	word_t           mem [depth];
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic            doPush;
	logic            doPop;

	// Wraps at depth so a non power of two still works
	function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
		return (ptr == ptrW'(depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign doPush = push & ~full;           // Overflow guard
	assign doPop  = pop & valid;            // Underflow guard
	assign valid  = (level != '0);
	assign full   = (level == levelW'(depth));
	assign head   = mem[rdPtr];

	always_ff @(posedge clk) begin
		if (doPush) begin
			mem[wrPtr] <= pushData;
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			level <= '0;
		end else begin
			if (doPush) wrPtr <= nextPtr(wrPtr);
			if (doPop) rdPtr <= nextPtr(rdPtr);
			case ({doPush, doPop})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;        // Both or neither
			endcase
		end
	end

endmodule

// File: design/busPort.sv
/*
	Host bus port
	Wishbone classic slave. Writes to the status address push instruction
	words into the queue and stall while it is full. Reads return the status
	word or one register of the execute unit
*/
`include "wisc_settings.svh"

module busPort
	import wisc_pkg::*;
(
	input  logic                     clk,
	input  logic                     rstN,
	input  wbReq_t                   wbIn,
	output wbRsp_t                   wbOut,
	output logic                     push,       // Queue write strobe
	output word_t                    pushData,
	input  logic                     full,
	input  logic [`QUEUE_LEVEL_W-1:0] level,
	input  logic                     halted,
	input  logic [7:0]               errCount,
	output regIdx_t                  rdIdx,      // Register read select
	input  word_t                    rdData
);

	logic  ackQ;        // Registered ack, high one cycle
	logic  newReq;
	logic  isInstrWr;
	logic  ackNext;
	word_t statusWord;
	word_t readMux;
	word_t datQ;        // Read data held for the ack cycle

	// A strobe already acked last cycle is the same request, not a new one
	assign newReq    = wbIn.cyc & wbIn.stb & ~ackQ;
	assign isInstrWr = wbIn.we & (wbIn.adr == `ADDR_STATUS);
	assign ackNext   = newReq & ~(isInstrWr & full);  // Hold off pushes while full
	assign push      = ackNext & isInstrWr;           // Same edge that raises ack
	assign pushData  = wbIn.dat;

	assign statusWord = {halted, 3'b000, level, errCount};
	assign rdIdx      = regIdx_t'(wbIn.adr - `ADDR_REG_BASE);

	always_comb begin
		if (wbIn.adr == `ADDR_STATUS) begin
			readMux = statusWord;
		end else if (wbIn.adr >= `ADDR_REG_BASE) begin
			readMux = rdData;           // Combinational register file read
		end else begin
			readMux = '0;               // Unmapped words read zero
		end
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			ackQ <= 1'b0;
		end else begin
			ackQ <= ackNext;            // Dropped stb just never acks
		end
	end

	always_ff @(posedge clk) begin
		if (ackNext & ~wbIn.we) begin
			datQ <= readMux;            // Sampled on the ack edge
		end
	end

	assign wbOut.ack = ackQ;
	assign wbOut.dat = datQ;

endmodule

// File: design/wisc_pkg.sv
/*
	WISC shared types
	Word and field widths, decoder enums, the control bundle
	and the Wishbone request and response structs
*/
package wisc_pkg;

	typedef logic [15:0] word_t;        // Data and instruction word
	typedef logic [4:0]  opcode_t;      // Instruction bits 15..11
	typedef logic [1:0]  funct_t;       // R format bits 1..0
	typedef logic [2:0]  regIdx_t;      // Register select
	typedef logic [3:0]  busAddr_t;     // Host word address

	// ALU function code of the WISC decoder
	typedef enum logic [2:0] {
		aluRol  = 3'b000,
		aluSll  = 3'b001,
		aluRor  = 3'b010,
		aluSrl  = 3'b011,
		aluAdd  = 3'b100,
		aluAndn = 3'b101,
		aluXor  = 3'b111
	} aluOp_t;

	typedef enum logic [1:0] {cmpEq, cmpLt, cmpLe, cmpCarry} cmpOp_t;     // Set-on-compare kind

	typedef enum logic [1:0] {spNone, spBtr, spLbi, spSlbi} specialOp_t;  // Non-ALU results

	typedef enum logic [1:0] {
		dstI1 = 2'b01,      // Bits 7..5
		dstR  = 2'b10,      // Bits 4..2
		dstRs = 2'b00       // Bits 10..8
	} dstSel_t;

	// Decoder output
	typedef struct packed {
		dstSel_t    dstSel;     // Destination field
		logic       useImm;     // Second operand is the 5-bit immediate
		logic       signImm;    // Sign-extend the immediate
		logic       invSrc1;    // Invert Rs and carry in for subtraction
		aluOp_t     aluOp;
		logic       cmpSet;     // Result is the compare bit
		cmpOp_t     cmpOp;
		specialOp_t special;
		logic       regWrite;
		logic       halt;
		logic       err;        // Opcode not executed here
	} ctrl_t;

	typedef struct packed {
		logic     cyc;
		logic     stb;
		logic     we;
		busAddr_t adr;
		word_t    dat;
	} wbReq_t;

	typedef struct packed {
		logic  ack;
		word_t dat;
	} wbRsp_t;

endpackage

// File: include/wisc_settings.svh
/*
	WISC instruction-stream engine settings
	Queue sizing, register file size and the host bus address map
*/
`ifndef WISC_SETTINGS_SVH
`define WISC_SETTINGS_SVH

// Instruction queue
`define QUEUE_DEPTH     8       // Entries in the instruction FIFO
`define QUEUE_LEVEL_W   4       // Level count holds 0 to QUEUE_DEPTH

// Register file
`define NUM_REGS        8       // R0 to R7

// Host bus word addresses
`define ADDR_STATUS     4'd0    // Write pushes an instruction, read gives status
`define ADDR_REG_BASE   4'd8    // Reads of 8 to 15 return R0 to R7

`endif
